//--- run.sh
#!/usr/bin/env bash
# Builds the store path testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_lsu_store_unit -Mdir obj_dir

out=$(./obj_dir/Vtb_lsu_store_unit)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- src.f
src/procyon_pkg.sv
src/lsu_id.sv
src/lsu_sq.sv
src/lsu_st_ex.sv
src/lsu_store_unit.sv
verification/lsu_checker.sv
verification/lsu_sq_sva.sv
verification/tb_lsu_store_unit.sv

//--- src/lsu_id.sv
/*
 * Address generation stage of the store path.
 * Adds base and offset of an issued store and registers the result as the
 * allocation request for the store queue one cycle later.
 */

`timescale 1ns/1ps

module lsu_id (
    input  logic                        clk,
    input  logic                        n_rst,

    input  logic                        i_flush,

    // Store op from the reservation station
    input  logic                        i_issue_en,
    input  procyon_pkg::procyon_issue_t i_issue,

    // Allocation request towards the store queue
    output logic                        o_alloc_en,
    output procyon_pkg::procyon_store_t o_alloc
);

    procyon_pkg::procyon_store_t alloc_next;

    // Effective address is the plain sum, no alignment checks are made here
    // The low address bits are left intact for the execute stage to use
    always_comb begin
        alloc_next.func = i_issue.func;
        alloc_next.addr = i_issue.base + i_issue.offset;
        alloc_next.data = i_issue.data;
        alloc_next.tag  = i_issue.tag;
    end

    // Request strobe
    // An issue that lands in a flush cycle is speculative by definition and
    // is dropped before it ever reaches the queue
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_alloc_en <= 1'b0;
        end else begin
            o_alloc_en <= i_issue_en & ~i_flush;
        end
    end

    // Request payload, only meaningful while o_alloc_en is high
    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_alloc <= alloc_next;
        end
    end

endmodule

//--- src/lsu_sq.sv
/*
 * Store queue of the LSU.
 * Holds each store until the ROB retires its tag, then launches it to the
 * execute stage in ROB order. Retried stores are relaunched, and a flush
 * drops every entry that has not yet been retired.
 */

`timescale 1ns/1ps

module lsu_sq (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,
    output logic                            o_full,

    // Allocation from the address stage
    input  logic                            i_alloc_en,
    input  procyon_pkg::procyon_store_t     i_alloc,

    // Launch towards the execute stage
    input  logic                            i_sq_retire_stall,
    output logic                            o_sq_retire_en,
    output procyon_pkg::procyon_sq_select_t o_sq_retire_select,
    output procyon_pkg::procyon_store_t     o_sq_retire,

    // Result of a launch, seen in the same cycle as the launch
    input  logic                            i_update_en,
    input  procyon_pkg::procyon_sq_select_t i_update_select,
    input  logic                            i_update_retry,

    // Retirement level from the ROB
    input  logic                            i_rob_retire_en,
    input  procyon_pkg::procyon_tag_t       i_rob_retire_tag,
    output logic                            o_rob_retire_ack
);

    // One queue entry, the three flag bits are the only control state
    typedef struct packed {
        procyon_pkg::procyon_store_t store;
        logic                        valid;
        logic                        nonspec;
        logic                        launched;
    } sq_entry_t;

    sq_entry_t [procyon_pkg::SQ_DEPTH-1:0] sq_entries;
    procyon_pkg::procyon_sq_select_t       sq_empty;
    procyon_pkg::procyon_sq_select_t       sq_retirable;
    procyon_pkg::procyon_sq_select_t       sq_held;
    procyon_pkg::procyon_sq_select_t       sq_alloc_select;
    procyon_pkg::procyon_sq_select_t       sq_rob_select;
    procyon_pkg::procyon_sq_select_t       sq_update_select;
    procyon_pkg::procyon_sq_select_t       sq_done_select;
    procyon_pkg::procyon_sq_select_t       sq_retire_select;
    logic                                  sq_pending;
    logic                                  launch_en;
    procyon_pkg::procyon_store_t           launch_store;

    assign sq_update_select = {procyon_pkg::SQ_DEPTH{i_update_en}} & i_update_select;
    // Entries whose write goes out this cycle and will be freed at the edge
    assign sq_done_select   = sq_update_select & {procyon_pkg::SQ_DEPTH{~i_update_retry}};

    always_comb begin
        for (int i = 0; i < procyon_pkg::SQ_DEPTH; i++) begin
            sq_empty[i]     = ~sq_entries[i].valid;
            sq_retirable[i] = sq_entries[i].valid & sq_entries[i].nonspec &
                              ~sq_entries[i].launched;
            // Retired but not yet written, ignoring a store that completes now
            sq_held[i]      = sq_entries[i].valid & sq_entries[i].nonspec & ~sq_done_select[i];
        end
    end

    // At most one retired store is outstanding at a time
    // This is what keeps memory writes in ROB retirement order, even across retries
    assign sq_pending = |sq_held;

    always_comb begin
        for (int i = 0; i < procyon_pkg::SQ_DEPTH; i++) begin
            sq_rob_select[i] = i_rob_retire_en & sq_entries[i].valid & ~sq_pending &
                               (sq_entries[i].store.tag == i_rob_retire_tag);
        end
    end

    // Lowest empty entry takes the new store
    assign sq_alloc_select = {procyon_pkg::SQ_DEPTH{i_alloc_en}} & (sq_empty & ~(sq_empty - 1'b1));
    assign o_full          = (sq_empty == '0);

    // Lowest retirable entry is launched unless memory is busy or we flush
    assign sq_retire_select = {procyon_pkg::SQ_DEPTH{~i_sq_retire_stall & ~i_flush}} &
                              (sq_retirable & ~(sq_retirable - 1'b1));
    assign launch_en        = |sq_retire_select;

    // One-hot mux of the launching entry
    always_comb begin
        launch_store = '0;
        for (int i = 0; i < procyon_pkg::SQ_DEPTH; i++) begin
            if (sq_retire_select[i]) begin
                launch_store = sq_entries[i].store;
            end
        end
    end

    // Ack goes back with the launch of the store the ROB is holding
    // A relaunch after a retry carries an older tag and does not ack again
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_rob_retire_ack <= 1'b0;
            o_sq_retire_en   <= 1'b0;
        end else begin
            o_rob_retire_ack <= i_rob_retire_en & launch_en &
                                (launch_store.tag == i_rob_retire_tag);
            o_sq_retire_en   <= launch_en;
        end
    end

    always_ff @(posedge clk) begin
        o_sq_retire        <= launch_store;
        o_sq_retire_select <= sq_retire_select;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < procyon_pkg::SQ_DEPTH; i++) begin
            if (sq_alloc_select[i]) begin
                sq_entries[i].store <= i_alloc;
            end

            if (!n_rst) begin
                sq_entries[i].valid    <= 1'b0;
                sq_entries[i].nonspec  <= 1'b0;
                sq_entries[i].launched <= 1'b0;
            end else begin
                // Flush keeps retired stores, they still have to reach memory
                // An allocation in the flush cycle is dropped along with the rest
                if (i_flush) begin
                    sq_entries[i].valid <= sq_entries[i].valid & sq_entries[i].nonspec &
                                           ~sq_done_select[i];
                end else if (sq_alloc_select[i]) begin
                    sq_entries[i].valid <= 1'b1;
                end else if (sq_done_select[i]) begin
                    sq_entries[i].valid <= 1'b0;
                end

                // Sticky once retired, so a retried store can still relaunch
                sq_entries[i].nonspec  <= ~sq_alloc_select[i] &
                                          (sq_entries[i].nonspec | sq_rob_select[i]);
                // A retry clears launched and the entry becomes retirable again
                sq_entries[i].launched <= ~sq_alloc_select[i] & (sq_retire_select[i] |
                                          (sq_update_select[i] ? ~i_update_retry
                                                               : sq_entries[i].launched));
            end
        end
    end

endmodule

//--- src/lsu_st_ex.sv
/*
 * Store execute stage.
 * Turns a launched store into an aligned word write with byte enables, or
 * sends it back to the store queue for retry while memory is busy.
 */

`timescale 1ns/1ps

module lsu_st_ex (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_mem_busy,

    // Launch from the store queue
    input  logic                            i_sq_retire_en,
    input  procyon_pkg::procyon_sq_select_t i_sq_retire_select,
    input  procyon_pkg::procyon_store_t     i_sq_retire,
    output logic                            o_sq_retire_stall,

    // Outcome of the launch back to the queue
    output logic                            o_update_en,
    output procyon_pkg::procyon_sq_select_t o_update_select,
    output logic                            o_update_retry,

    // Memory write port
    output logic                            o_mem_wr_en,
    output procyon_pkg::procyon_mem_wr_t    o_mem_wr
);

    logic [procyon_pkg::BYTE_OFF_W-1:0] lane;
    logic [procyon_pkg::BE_W-1:0]       be_base;
    procyon_pkg::procyon_data_t         data_masked;
    procyon_pkg::procyon_mem_wr_t       mem_wr_next;

    // Byte lane and unshifted enable per opcode
    // A halfword uses only address bit 1, so it always stays inside the word
    always_comb begin
        lane        = i_sq_retire.addr[procyon_pkg::BYTE_OFF_W-1:0];
        be_base     = '0;
        data_masked = '0;
        case (i_sq_retire.func)
            procyon_pkg::LSU_FUNC_SB: begin
                be_base           = procyon_pkg::BE_W'(4'b0001);
                data_masked[7:0]  = i_sq_retire.data[7:0];
            end
            procyon_pkg::LSU_FUNC_SH: begin
                lane[0]           = 1'b0;
                be_base           = procyon_pkg::BE_W'(4'b0011);
                data_masked[15:0] = i_sq_retire.data[15:0];
            end
            procyon_pkg::LSU_FUNC_SW: begin
                lane              = '0;
                be_base           = '1;
                data_masked       = i_sq_retire.data;
            end
            default: begin
                // Unused opcode writes no bytes
                lane              = '0;
            end
        endcase

        mem_wr_next.addr = i_sq_retire.addr[procyon_pkg::ADDR_W-1:procyon_pkg::BYTE_OFF_W];
        mem_wr_next.be   = be_base << lane;
        mem_wr_next.data = data_masked << {lane, 3'b000};
        mem_wr_next.tag  = i_sq_retire.tag;
    end

    // Busy memory both stalls new launches and bounces the one in flight
    assign o_sq_retire_stall = i_mem_busy;
    assign o_update_en       = i_sq_retire_en;
    assign o_update_select   = i_sq_retire_select;
    assign o_update_retry    = i_mem_busy;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_mem_wr_en <= 1'b0;
        end else begin
            o_mem_wr_en <= i_sq_retire_en & ~i_mem_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (i_sq_retire_en) begin
            o_mem_wr <= mem_wr_next;
        end
    end

endmodule

//--- src/lsu_store_unit.sv
/*
 * Store path top level.
 * Chains the address stage, the store queue and the execute stage. The ROB
 * and the memory sit outside and talk through the ports below.
 */

`timescale 1ns/1ps

module lsu_store_unit (
    input  logic                         clk,
    input  logic                         n_rst,

    input  logic                         i_flush,

    // Issue from the reservation station, never pulsed while full
    input  logic                         i_issue_en,
    input  procyon_pkg::procyon_issue_t  i_issue,
    output logic                         o_sq_full,

    // ROB retirement level and its ack
    input  logic                         i_rob_retire_en,
    input  procyon_pkg::procyon_tag_t    i_rob_retire_tag,
    output logic                         o_rob_retire_ack,

    // Memory side
    input  logic                         i_mem_busy,
    output logic                         o_mem_wr_en,
    output procyon_pkg::procyon_mem_wr_t o_mem_wr
);

    logic                            alloc_en;
    procyon_pkg::procyon_store_t     alloc;
    logic                            retire_en;
    procyon_pkg::procyon_store_t     retire;
    procyon_pkg::procyon_sq_select_t retire_select;
    logic                            retire_stall;
    logic                            update_en;
    procyon_pkg::procyon_sq_select_t update_select;
    logic                            update_retry;

    lsu_id lsu_id_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_flush    (i_flush),
        .i_issue_en (i_issue_en),
        .i_issue    (i_issue),
        .o_alloc_en (alloc_en),
        .o_alloc    (alloc)
    );

    lsu_sq lsu_sq_inst (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .o_full             (o_sq_full),
        .i_alloc_en         (alloc_en),
        .i_alloc            (alloc),
        .i_sq_retire_stall  (retire_stall),
        .o_sq_retire_en     (retire_en),
        .o_sq_retire_select (retire_select),
        .o_sq_retire        (retire),
        .i_update_en        (update_en),
        .i_update_select    (update_select),
        .i_update_retry     (update_retry),
        .i_rob_retire_en    (i_rob_retire_en),
        .i_rob_retire_tag   (i_rob_retire_tag),
        .o_rob_retire_ack   (o_rob_retire_ack)
    );

    lsu_st_ex lsu_st_ex_inst (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_mem_busy         (i_mem_busy),
        .i_sq_retire_en     (retire_en),
        .i_sq_retire_select (retire_select),
        .i_sq_retire        (retire),
        .o_sq_retire_stall  (retire_stall),
        .o_update_en        (update_en),
        .o_update_select    (update_select),
        .o_update_retry     (update_retry),
        .o_mem_wr_en        (o_mem_wr_en),
        .o_mem_wr           (o_mem_wr)
    );

endmodule

//--- src/procyon_pkg.sv
/*
 * Shared constants, opcodes and bus records for the store path of the LSU.
 * RTL and testbench refer to these by scoped name, never by import.
 */

package procyon_pkg;

    // Queue size and datapath widths
    localparam int SQ_DEPTH   = 8;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int TAG_W      = 6;
    // One enable bit per byte of a data word
    localparam int BE_W       = DATA_W / 8;
    localparam int BYTE_OFF_W = $clog2(BE_W);

    typedef logic [ADDR_W-1:0]   procyon_addr_t;
    typedef logic [DATA_W-1:0]   procyon_data_t;
    typedef logic [TAG_W-1:0]    procyon_tag_t;
    // One-hot name of a store queue entry
    typedef logic [SQ_DEPTH-1:0] procyon_sq_select_t;

    // Store opcodes, the encoding 2'b11 is unused
    typedef enum logic [1:0] {
        LSU_FUNC_SB = 2'b00,
        LSU_FUNC_SH = 2'b01,
        LSU_FUNC_SW = 2'b10
    } procyon_lsu_func_t;

    // Store op as it leaves the reservation station
    typedef struct packed {
        procyon_lsu_func_t func;
        procyon_addr_t     base;
        procyon_addr_t     offset;
        procyon_data_t     data;
        procyon_tag_t      tag;
    } procyon_issue_t;

    // Store with its effective address resolved, used for allocation and launch
    typedef struct packed {
        procyon_lsu_func_t func;
        procyon_addr_t     addr;
        procyon_data_t     data;
        procyon_tag_t      tag;
    } procyon_store_t;

    // Aligned write as presented to the memory port
    typedef struct packed {
        logic [ADDR_W-BYTE_OFF_W-1:0] addr;
        logic [BE_W-1:0]              be;
        procyon_data_t                data;
        procyon_tag_t                 tag;
    } procyon_mem_wr_t;

endpackage

//--- verification/lsu_checker.sv
/*
 * Watches the store unit ports and checks every memory write.
 * Stores are predicted at issue, queued in order as their acks arrive and
 * compared against the write port. Counts are exported for the testbench.
 */

`timescale 1ns/1ps

module lsu_checker (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_issue_en,
    input  procyon_pkg::procyon_issue_t  i_issue,
    input  logic                         i_rob_retire_en,
    input  procyon_pkg::procyon_tag_t    i_rob_retire_tag,
    input  logic                         i_rob_retire_ack,
    input  logic                         i_mem_wr_en,
    input  procyon_pkg::procyon_mem_wr_t i_mem_wr,
    output int                           o_err_count,
    output int                           o_write_count,
    output int                           o_pending
);

    localparam int N_TAGS = 2 ** procyon_pkg::TAG_W;

    procyon_pkg::procyon_mem_wr_t expect_by_tag [N_TAGS];
    logic                         acked [N_TAGS];
    procyon_pkg::procyon_mem_wr_t ref_q [$];
    procyon_pkg::procyon_mem_wr_t exp_wr;
    logic                         prev_en;
    procyon_pkg::procyon_tag_t    prev_tag;
    int                           err_count;
    int                           write_count;

    assign o_err_count   = err_count;
    assign o_write_count = write_count;
    assign o_pending     = ref_q.size();

    // Word address, byte lanes and shifted data from the effective address
    function automatic procyon_pkg::procyon_mem_wr_t predict_write(
        procyon_pkg::procyon_issue_t op);
        procyon_pkg::procyon_mem_wr_t w;
        procyon_pkg::procyon_addr_t   ea;
        int                           lane;
        ea     = op.base + op.offset;
        lane   = int'(ea[1:0]);
        w.addr = ea[31:2];
        w.tag  = op.tag;
        case (op.func)
            procyon_pkg::LSU_FUNC_SB: begin
                w.be   = 4'b0001 << lane;
                w.data = {24'h0, op.data[7:0]} << (8 * lane);
            end
            procyon_pkg::LSU_FUNC_SH: begin
                lane   = lane & 2;
                w.be   = 4'b0011 << lane;
                w.data = {16'h0, op.data[15:0]} << (8 * lane);
            end
            procyon_pkg::LSU_FUNC_SW: begin
                w.be   = 4'b1111;
                w.data = op.data;
            end
            default: begin
                w.be   = 4'b0000;
                w.data = '0;
            end
        endcase
        return w;
    endfunction

    // Sampled before the edge updates, so every value is the one just past
    always @(posedge clk) begin
        if (!n_rst) begin
            prev_en     = 1'b0;
            prev_tag    = '0;
            err_count   = 0;
            write_count = 0;
            ref_q.delete();
            for (int t = 0; t < N_TAGS; t++) begin
                acked[t] = 1'b0;
            end
        end else begin
            if (i_issue_en) begin
                expect_by_tag[i_issue.tag] = predict_write(i_issue);
                acked[i_issue.tag]         = 1'b0;
            end
            // The ROB may already have moved on, so the acked tag is last cycle's
            if (i_rob_retire_ack) begin
                if (!prev_en) begin
                    $display("ERR %0t: ack arrived with no tag presented", $time);
                    err_count++;
                end else if (acked[prev_tag]) begin
                    $display("ERR %0t: second ack for tag %0h", $time, prev_tag);
                    err_count++;
                end else begin
                    acked[prev_tag] = 1'b1;
                    ref_q.push_back(expect_by_tag[prev_tag]);
                end
            end
            if (i_mem_wr_en) begin
                write_count++;
                if (ref_q.size() == 0) begin
                    $display("ERR %0t: unexpected write, tag %0h addr %h", $time,
                             i_mem_wr.tag, i_mem_wr.addr);
                    err_count++;
                end else begin
                    exp_wr = ref_q.pop_front();
                    if (i_mem_wr !== exp_wr) begin
                        $write("ERR %0t: write tag %0h addr %h be %b data %h", $time,
                               i_mem_wr.tag, i_mem_wr.addr, i_mem_wr.be, i_mem_wr.data);
                        $display(", expected tag %0h addr %h be %b data %h",
                                 exp_wr.tag, exp_wr.addr, exp_wr.be, exp_wr.data);
                        err_count++;
                    end
                end
            end
            prev_en  = i_rob_retire_en;
            prev_tag = i_rob_retire_tag;
        end
    end

endmodule

//--- verification/lsu_sq_sva.sv
/*
 * Concurrent assertions on the store queue launch and ack logic.
 * Bound into every lsu_sq instance from the bind statement below.
 */

`timescale 1ns/1ps

module lsu_sq_sva (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic                            i_sq_retire_stall,
    input  logic                            o_sq_retire_en,
    input  procyon_pkg::procyon_sq_select_t o_sq_retire_select,
    input  logic                            o_rob_retire_ack
);

    // At most one entry is named by a launch
    launch_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(o_sq_retire_select))
        else $error("store queue launch select names more than one entry");

    // A busy memory blocks the launch registered at the same edge
    stall_blocks_launch: assert property (@(posedge clk) disable iff (!n_rst)
        i_sq_retire_stall |=> !o_sq_retire_en)
        else $error("store queue launched while the execute stage stalled");

    // Ack stays low out of reset
    ack_after_reset: assert property (@(posedge clk)
        !n_rst |=> !o_rob_retire_ack)
        else $error("ROB ack high right after reset");

endmodule

bind lsu_sq lsu_sq_sva sva_inst (
    .clk                (clk),
    .n_rst              (n_rst),
    .i_sq_retire_stall  (i_sq_retire_stall),
    .o_sq_retire_en     (o_sq_retire_en),
    .o_sq_retire_select (o_sq_retire_select),
    .o_rob_retire_ack   (o_rob_retire_ack)
);

//--- verification/tb_lsu_store_unit.sv
/*
 * Testbench for the store unit.
 * Issues a table of stores, plays the ROB retiring them in table order and
 * drives a random busy memory. lsu_checker does the write comparisons.
 */

`timescale 1ns/1ps

module tb_lsu_store_unit;

    localparam int N_ROWS         = 12;
    localparam int BATCH0         = 8;
    localparam int TIMEOUT_CYCLES = N_ROWS * 40;

    // One store per row and flush_after pulses a flush once the row is acked
    typedef struct packed {
        procyon_pkg::procyon_lsu_func_t func;
        procyon_pkg::procyon_addr_t     base;
        procyon_pkg::procyon_addr_t     offset;
        procyon_pkg::procyon_data_t     data;
        procyon_pkg::procyon_tag_t      tag;
        logic                           flush_after;
    } stim_row_t;

    logic                         clk;
    logic                         n_rst;
    logic                         i_flush;
    logic                         i_issue_en;
    procyon_pkg::procyon_issue_t  i_issue;
    logic                         o_sq_full;
    logic                         i_rob_retire_en;
    procyon_pkg::procyon_tag_t    i_rob_retire_tag;
    logic                         o_rob_retire_ack;
    logic                         i_mem_busy;
    logic                         o_mem_wr_en;
    procyon_pkg::procyon_mem_wr_t o_mem_wr;
    int                           chk_errors;
    int                           chk_writes;
    int                           chk_pending;

    stim_row_t stim [N_ROWS];
    logic [7:0] lfsr;
    int         tb_errors;
    int         expected_writes;
    int         flush_row;

    lsu_store_unit UUT (.*);

    lsu_checker chk (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_issue_en       (i_issue_en),
        .i_issue          (i_issue),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .i_rob_retire_ack (o_rob_retire_ack),
        .i_mem_wr_en      (o_mem_wr_en),
        .i_mem_wr         (o_mem_wr),
        .o_err_count      (chk_errors),
        .o_write_count    (chk_writes),
        .o_pending        (chk_pending)
    );

    // Taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic issue_row(int idx);
        @(negedge clk);
        i_issue_en    = 1'b1;
        i_issue.func   = stim[idx].func;
        i_issue.base   = stim[idx].base;
        i_issue.offset = stim[idx].offset;
        i_issue.data   = stim[idx].data;
        i_issue.tag    = stim[idx].tag;
        @(negedge clk);
        i_issue_en    = 1'b0;
    endtask

    // Hold the tag as a level until the ack and then drop it
    task automatic retire_row(int idx);
        @(negedge clk);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = stim[idx].tag;
        do begin
            @(negedge clk);
        end while (!o_rob_retire_ack);
        i_rob_retire_en = 1'b0;
    endtask

    // Name a flushed tag as a retiring one, the queue must not ack it
    task automatic probe_flushed_row(int idx);
        @(negedge clk);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = stim[idx].tag;
        repeat (4) begin
            @(negedge clk);
            if (o_rob_retire_ack) begin
                $display("ERR %0t: flushed tag %0h was acked", $time, stim[idx].tag);
                tb_errors++;
            end
        end
        i_rob_retire_en = 1'b0;
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
    endtask

    task automatic check_full(logic expected);
        if (o_sq_full !== expected) begin
            $display("ERR %0t: o_sq_full is %b, expected %b", $time, o_sq_full, expected);
            tb_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timed out: the stores did not drain within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // Memory busy takes one LFSR bit per cycle once out of reset
    initial begin
        lfsr       = 8'd26;
        i_mem_busy = 1'b0;
        @(posedge n_rst);
        forever begin
            @(negedge clk);
            lfsr       = lfsr_next(lfsr);
            i_mem_busy = lfsr[0];
        end
    end

    initial begin
        // Sizes, lanes and a wrapping negative offset in the first batch
        stim[0]  = '{procyon_pkg::LSU_FUNC_SB, 32'h1000_0000, 32'h1, 32'hA5A5_A5C3, 6'h01, 1'b0};
        stim[1]  = '{procyon_pkg::LSU_FUNC_SH, 32'h1000_0010, 32'h2, 32'h1234_BEEF, 6'h02, 1'b0};
        stim[2]  = '{procyon_pkg::LSU_FUNC_SW, 32'h1000_0020, 32'h4, 32'hDEAD_BEEF, 6'h03, 1'b0};
        stim[3]  = '{procyon_pkg::LSU_FUNC_SB, 32'h1000_0030, 32'h3, 32'h0000_007E, 6'h04, 1'b0};
        stim[4]  = '{procyon_pkg::LSU_FUNC_SH, 32'h1000_0031, 32'h5, 32'hFFFF_5AA5, 6'h05, 1'b0};
        stim[5]  = '{procyon_pkg::LSU_FUNC_SB, 32'h2000_0000, 32'hFFFF_FFFE, 32'h0000_0091, 6'h06, 1'b0};
        stim[6]  = '{procyon_pkg::LSU_FUNC_SW, 32'h3000_0100, 32'h0, 32'h0BAD_F00D, 6'h07, 1'b0};
        stim[7]  = '{procyon_pkg::LSU_FUNC_SB, 32'h3000_0200, 32'h4, 32'h1122_3344, 6'h08, 1'b0};
        // Only the first store of the second batch survives the flush
        stim[8]  = '{procyon_pkg::LSU_FUNC_SW, 32'h4000_0000, 32'h8, 32'hCAFE_0001, 6'h09, 1'b1};
        stim[9]  = '{procyon_pkg::LSU_FUNC_SH, 32'h4000_0010, 32'h2, 32'hCAFE_0002, 6'h0A, 1'b0};
        stim[10] = '{procyon_pkg::LSU_FUNC_SB, 32'h4000_0020, 32'h1, 32'hCAFE_0003, 6'h0B, 1'b0};
        stim[11] = '{procyon_pkg::LSU_FUNC_SW, 32'h4000_0030, 32'h0, 32'hCAFE_0004, 6'h0C, 1'b0};

        n_rst            = 1'b0;
        i_flush          = 1'b0;
        i_issue_en       = 1'b0;
        i_issue          = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        tb_errors        = 0;
        expected_writes  = 0;
        flush_row        = N_ROWS;
        repeat (5) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // Allocate in reverse so the ROB order differs from the queue order
        for (int i = BATCH0 - 1; i >= 0; i--) begin
            issue_row(i);
        end
        @(negedge clk);
        check_full(1'b1);

        for (int i = 0; i < BATCH0; i++) begin
            retire_row(i);
            expected_writes++;
            if (i == 0) begin
                while (chk_writes < 1) begin
                    @(negedge clk);
                end
                check_full(1'b0);
            end
        end

        for (int i = BATCH0; i < N_ROWS; i++) begin
            issue_row(i);
        end
        for (int i = BATCH0; i < N_ROWS; i++) begin
            retire_row(i);
            expected_writes++;
            if (stim[i].flush_after) begin
                pulse_flush();
                flush_row = i;
                break;
            end
        end

        // Drain and then linger so that any write of a flushed store would show up
        while (chk_writes < expected_writes) begin
            @(negedge clk);
        end
        // Stores dropped by the flush stay dead even when their tags are named
        for (int i = flush_row + 1; i < N_ROWS; i++) begin
            probe_flushed_row(i);
        end
        repeat (20) @(negedge clk);

        if (chk_writes != expected_writes || chk_pending != 0) begin
            $display("ERR %0t: %0d writes seen, %0d expected, %0d acked stores unwritten",
                     $time, chk_writes, expected_writes, chk_pending);
            tb_errors++;
        end

        $display("Errors: checker %0d, testbench %0d; writes %0d of %0d",
                 chk_errors, tb_errors, chk_writes, expected_writes);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
